//--- rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    ////////////////////
    // address fields
    ////////////////////

    localparam int ADDR_W         = 30;  // cpu word address
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_W       = 2;   // word within line
    localparam int INDEX_W        = 8;   // set select
    localparam int SETS           = 256;
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;  // 20 bits
    localparam int LINE_ADDR_W    = TAG_W + INDEX_W;              // tag then index

    ////////////////////
    // storage types
    ////////////////////

    // word 0 sits in the low 32 bits
    typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;  // line differs from l2
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    ////////////////////
    // controller
    ////////////////////

    typedef enum logic [2:0] {
        ST_IDLE,     // wait for cpu, also covers the array read cycle
        ST_LOOKUP,   // tag compare on array output
        ST_WAIT_L2,  // miss held while l2 not free
        ST_REFILL,   // l2 request out, wait for line
        ST_DONE      // refill written, answer cpu
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/dcache_array_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dcache_array_if;
    import dcache_pkg::*;

    // write side, one enable bit per way
    logic [INDEX_W-1:0] index;
    logic [1:0]         tag_we;
    logic [1:0]         data_we;
    tag_entry_t         wr_tag;
    line_t              wr_line;

    // registered read results
    tag_entry_t         rd_tag  [2];
    line_t              rd_line [2];

    modport ctrl (
        output index, tag_we, data_we, wr_tag, wr_line,
        input  rd_tag, rd_line
    );

    modport lookup (
        input index, rd_tag, rd_line
    );

    // array side as seen from the top level
    modport ram (
        input  index, tag_we, data_we, wr_tag, wr_line,
        output rd_tag, rd_line
    );

endinterface

`default_nettype wire

//--- rtl/dcache_way_ram.sv
`timescale 1ns/1ps
`default_nettype none

// one way of the cache, shared by tag and data storage
module dcache_way_ram #(
    parameter int  DEPTH   = 256,
    parameter type entry_t = logic [31:0]
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [dcache_pkg::INDEX_W-1:0] index,
    input  logic                         we,
    input  entry_t                       wr_entry,
    output entry_t                       rd_entry
);

    entry_t mem [DEPTH];

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;  // all tags invalid
            end
            rd_entry <= '0;
        end else begin
            if (we) begin
                mem[index] <= wr_entry;
            end
            rd_entry <= mem[index];  // old contents on a write cycle
        end
    end

endmodule

`default_nettype wire

//--- rtl/dcache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup (
    input  logic                            clk,
    input  logic                            arst_n,
    dcache_array_if.lookup                  arr,
    input  logic [dcache_pkg::TAG_W-1:0]    cmp_tag,
    input  logic [dcache_pkg::OFFSET_W-1:0] offset,
    input  logic                            lru_touch,
    input  logic                            touch_way,
    output logic                            hit,
    output logic                            hit_way,
    output logic                            victim_way,
    output dcache_pkg::tag_entry_t          victim_entry,
    output dcache_pkg::line_t               victim_line,
    output logic [dcache_pkg::WORD_W-1:0]   sel_word,
    output dcache_pkg::line_t               hit_line
);
    import dcache_pkg::*;

    logic            hit0;
    logic            hit1;
    logic [SETS-1:0] lru_q;  // names the way to evict next

    ////////////////////
    // tag compare
    ////////////////////

    assign hit0 = arr.rd_tag[0].valid && (arr.rd_tag[0].tag == cmp_tag);
    assign hit1 = arr.rd_tag[1].valid && (arr.rd_tag[1].tag == cmp_tag);

    assign hit     = hit0 || hit1;
    assign hit_way = !hit0;  // way 0 wins if both match

    assign hit_line = arr.rd_line[hit_way];
    assign sel_word = hit_line[offset];

    ////////////////////
    // victim choice
    ////////////////////

    always_comb begin
        if (!arr.rd_tag[0].valid) begin
            victim_way = 1'b0;
        end else if (!arr.rd_tag[1].valid) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[arr.index];
        end
    end

    assign victim_entry = arr.rd_tag[victim_way];
    assign victim_line  = arr.rd_line[victim_way];

    ////////////////////
    // lru bits
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_q <= '0;
        end else if (lru_touch) begin
            lru_q[arr.index] <= !touch_way;  // evict the other way next
        end
    end

endmodule

`default_nettype wire

//--- rtl/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic                               clk,
    input  logic                               arst_n,
    // cpu side
    input  logic                               cpu_req,
    input  logic                               cpu_we,
    input  logic [dcache_pkg::ADDR_W-1:0]      cpu_addr,
    input  logic [dcache_pkg::WORD_W-1:0]      cpu_wdata,
    output logic                               cpu_busy,
    output logic                               cpu_done,
    output logic [dcache_pkg::WORD_W-1:0]      cpu_rdata,
    // l2 side
    input  logic                               l2_free,
    output logic                               l2_req,
    output logic                               l2_wb,
    output logic [dcache_pkg::LINE_ADDR_W-1:0] l2_addr,
    output logic [dcache_pkg::LINE_ADDR_W-1:0] l2_wb_addr,
    output dcache_pkg::line_t                  l2_wb_line,
    input  logic                               l2_rdy,
    input  dcache_pkg::line_t                  l2_rdata,
    // arrays and lookup
    dcache_array_if.ctrl                       arr,
    output logic [dcache_pkg::TAG_W-1:0]       cmp_tag,
    output logic [dcache_pkg::OFFSET_W-1:0]    offset,
    input  logic                               hit,
    input  logic                               hit_way,
    input  logic                               victim_way,
    input  dcache_pkg::tag_entry_t             victim_entry,
    input  dcache_pkg::line_t                  victim_line,
    input  logic [dcache_pkg::WORD_W-1:0]      sel_word,
    input  dcache_pkg::line_t                  hit_line,
    output logic                               lru_touch,
    output logic                               touch_way
);
    import dcache_pkg::*;

    ctrl_state_t         state_q;
    ctrl_state_t         state_d;
    logic                req_pend_q;  // request taken, arrays reading
    logic                accept;
    logic [ADDR_W-1:0]   addr_q;
    logic                we_q;
    logic [WORD_W-1:0]   wdata_q;
    logic                way_q;       // way that receives the refill
    logic [WORD_W-1:0]   rdata_q;
    logic                wr_way;
    logic                line_wr;
    line_t               merge_base;
    line_t               merge_line;

    ////////////////////
    // request latch
    ////////////////////

    assign accept = cpu_req && !cpu_busy;

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= cpu_addr;
            we_q    <= cpu_we;
            wdata_q <= cpu_wdata;
        end
        if (state_q == ST_LOOKUP) begin
            way_q <= victim_way;  // stays put until the refill
        end
        if (state_q == ST_REFILL && l2_rdy) begin
            rdata_q <= l2_rdata[offset];
        end
    end

    assign cmp_tag   = addr_q[ADDR_W-1 -: TAG_W];
    assign offset    = addr_q[OFFSET_W-1:0];
    assign arr.index = addr_q[OFFSET_W +: INDEX_W];

    ////////////////////
    // state machine
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= ST_IDLE;
            req_pend_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            req_pend_q <= accept;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_pend_q) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit) begin
                    state_d = ST_IDLE;
                end else if (l2_free) begin
                    state_d = ST_REFILL;
                end else begin
                    state_d = ST_WAIT_L2;
                end
            end
            ST_WAIT_L2: begin
                if (l2_free) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (l2_rdy) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    ////////////////////
    // cpu strobes
    ////////////////////

    assign cpu_busy  = (state_q != ST_IDLE) || req_pend_q;
    assign cpu_done  = (state_q == ST_LOOKUP && hit) || (state_q == ST_DONE);
    assign cpu_rdata = (state_q == ST_LOOKUP) ? sel_word : rdata_q;

    assign lru_touch = cpu_done;
    assign touch_way = (state_q == ST_LOOKUP) ? hit_way : way_q;

    ////////////////////
    // l2 strobes
    ////////////////////

    assign l2_req = l2_free && ((state_q == ST_LOOKUP && !hit) || state_q == ST_WAIT_L2);
    assign l2_wb  = l2_req && victim_entry.valid && victim_entry.dirty;

    assign l2_addr    = addr_q[ADDR_W-1:OFFSET_W];
    assign l2_wb_addr = {victim_entry.tag, arr.index};
    assign l2_wb_line = victim_line;

    ////////////////////
    // array writes
    ////////////////////

    // write hit in lookup, refill on the l2_rdy cycle
    assign line_wr    = (state_q == ST_LOOKUP && hit && we_q) || (state_q == ST_REFILL && l2_rdy);
    assign wr_way     = (state_q == ST_REFILL) ? way_q : hit_way;
    assign merge_base = (state_q == ST_REFILL) ? l2_rdata : hit_line;

    always_comb begin
        merge_line = merge_base;
        if (we_q) begin
            merge_line[offset] = wdata_q;  // cpu word over the line
        end
    end

    assign arr.tag_we  = line_wr ? (2'b01 << wr_way) : 2'b00;
    assign arr.data_we = arr.tag_we;
    assign arr.wr_line = merge_line;
    assign arr.wr_tag  = '{valid: 1'b1, dirty: we_q, tag: cmp_tag};

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               cpu_req,
    input  logic                               cpu_we,
    input  logic [dcache_pkg::ADDR_W-1:0]      cpu_addr,
    input  logic [dcache_pkg::WORD_W-1:0]      cpu_wdata,
    output logic                               cpu_busy,
    output logic                               cpu_done,
    output logic [dcache_pkg::WORD_W-1:0]      cpu_rdata,
    input  logic                               l2_free,
    output logic                               l2_req,
    output logic                               l2_wb,
    output logic [dcache_pkg::LINE_ADDR_W-1:0] l2_addr,
    output logic [dcache_pkg::LINE_ADDR_W-1:0] l2_wb_addr,
    output dcache_pkg::line_t                  l2_wb_line,
    input  logic                               l2_rdy,
    input  dcache_pkg::line_t                  l2_rdata
);
    import dcache_pkg::*;

    logic [TAG_W-1:0]    cmp_tag;
    logic [OFFSET_W-1:0] offset;
    logic                hit;
    logic                hit_way;
    logic                victim_way;
    tag_entry_t          victim_entry;
    line_t               victim_line;
    logic [WORD_W-1:0]   sel_word;
    line_t               hit_line;
    logic                lru_touch;
    logic                touch_way;

    dcache_array_if arr ();

    dcache_ctrl u_ctrl (
        .clk, .arst_n,
        .cpu_req, .cpu_we, .cpu_addr, .cpu_wdata,
        .cpu_busy, .cpu_done, .cpu_rdata,
        .l2_free, .l2_req, .l2_wb, .l2_addr, .l2_wb_addr, .l2_wb_line,
        .l2_rdy, .l2_rdata,
        .arr       (arr.ctrl),
        .cmp_tag, .offset,
        .hit, .hit_way, .victim_way, .victim_entry, .victim_line,
        .sel_word, .hit_line,
        .lru_touch, .touch_way
    );

    dcache_lookup u_lookup (
        .clk, .arst_n,
        .arr       (arr.lookup),
        .cmp_tag, .offset, .lru_touch, .touch_way,
        .hit, .hit_way, .victim_way, .victim_entry, .victim_line,
        .sel_word, .hit_line
    );

    ////////////////////
    // way arrays
    ////////////////////

    for (genvar w = 0; w < 2; w++) begin : g_way
        dcache_way_ram #(.DEPTH(SETS), .entry_t(tag_entry_t)) u_tag (
            .clk, .arst_n,
            .index    (arr.index),
            .we       (arr.tag_we[w]),
            .wr_entry (arr.wr_tag),
            .rd_entry (arr.rd_tag[w])
        );

        dcache_way_ram #(.DEPTH(SETS), .entry_t(line_t)) u_data (
            .clk, .arst_n,
            .index    (arr.index),
            .we       (arr.data_we[w]),
            .wr_entry (arr.wr_line),
            .rd_entry (arr.rd_line[w])
        );
    end

endmodule

`default_nettype wire

//--- verif/dcache_l2_model.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_l2_model #(
    parameter int DELAY    = 3,  // edges from l2_req to l2_rdy
    parameter int WB_SLOTS = 8
) (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               stall,       // hold l2_free low
    input  logic                               l2_req,
    input  logic                               l2_wb,
    input  logic [dcache_pkg::LINE_ADDR_W-1:0] l2_addr,
    input  logic [dcache_pkg::LINE_ADDR_W-1:0] l2_wb_addr,
    input  dcache_pkg::line_t                  l2_wb_line,
    output logic                               l2_free,
    output logic                               l2_rdy,
    output dcache_pkg::line_t                  l2_rdata,
    output logic [dcache_pkg::LINE_ADDR_W-1:0] fill_addr,   // line never written back
    input  dcache_pkg::line_t                  fill_line
);
    import dcache_pkg::*;

    logic                   busy_q;
    logic                   rdy_q;
    int                     cnt_q;
    logic [LINE_ADDR_W-1:0] addr_q;
    line_t                  rdata_q;
    logic [LINE_ADDR_W-1:0] wb_addr_tab [WB_SLOTS];  // write-back record
    line_t                  wb_line_tab [WB_SLOTS];
    int                     wb_n;

    function automatic int find_slot(input logic [LINE_ADDR_W-1:0] a);
        int slot;
        slot = wb_n;
        for (int i = 0; i < wb_n; i++) begin
            if (wb_addr_tab[i] == a) begin
                slot = i;
            end
        end
        return slot;
    endfunction

    assign fill_addr   = addr_q;
    assign #1 l2_free  = !stall && !busy_q && !rdy_q;
    assign #1 l2_rdy   = rdy_q;
    assign #1 l2_rdata = rdata_q;

    always @(posedge clk or negedge arst_n) begin : serve
        int slot;
        if (!arst_n) begin
            busy_q  <= 1'b0;
            rdy_q   <= 1'b0;
            cnt_q   <= 0;
            addr_q  <= '0;
            rdata_q <= '0;
            wb_n    <= 0;
        end else begin
            rdy_q <= 1'b0;  // one cycle pulse
            if (l2_req) begin
                busy_q <= 1'b1;
                cnt_q  <= 1;
                addr_q <= l2_addr;
                slot = find_slot(l2_wb_addr);
                if (l2_wb && slot < WB_SLOTS) begin
                    wb_addr_tab[slot] <= l2_wb_addr;
                    wb_line_tab[slot] <= l2_wb_line;
                    if (slot == wb_n) begin
                        wb_n <= wb_n + 1;
                    end
                end
            end else if (busy_q) begin
                if (cnt_q == DELAY) begin
                    slot = find_slot(addr_q);
                    busy_q  <= 1'b0;
                    rdy_q   <= 1'b1;
                    rdata_q <= (slot < wb_n) ? wb_line_tab[slot] : fill_line;
                end else begin
                    cnt_q <= cnt_q + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int                 LIMIT = 50;  // cycles per wait
    localparam int                 HOLD  = 6;
    localparam logic [31:0]        SEED  = 32'd14;
    localparam logic [TAG_W-1:0]   TAG_A = 20'h12345;
    localparam logic [INDEX_W-1:0] IDX_A = 8'h10;
    localparam logic [TAG_W-1:0]   T1    = 20'h00aaa;
    localparam logic [TAG_W-1:0]   T2    = 20'h00bbb;
    localparam logic [TAG_W-1:0]   T3    = 20'h00ccc;
    localparam logic [INDEX_W-1:0] IDX_E = 8'h2a;  // eviction set
    localparam logic [TAG_W-1:0]   TAG_S = 20'h05555;
    localparam logic [INDEX_W-1:0] IDX_S = 8'h55;

    logic                   clk;
    logic                   arst_n;
    logic                   cpu_req;
    logic                   cpu_we;
    logic [ADDR_W-1:0]      cpu_addr;
    logic [WORD_W-1:0]      cpu_wdata;
    logic                   cpu_busy;
    logic                   cpu_done;
    logic [WORD_W-1:0]      cpu_rdata;
    logic                   l2_free;
    logic                   l2_req;
    logic                   l2_wb;
    logic [LINE_ADDR_W-1:0] l2_addr;
    logic [LINE_ADDR_W-1:0] l2_wb_addr;
    line_t                  l2_wb_line;
    logic                   l2_rdy;
    line_t                  l2_rdata;
    logic                   stall;
    logic [LINE_ADDR_W-1:0] fill_addr;
    line_t                  fill_line;

    // what the current access should produce
    logic                   seen_req;
    logic                   in_flight;
    logic                   exp_hit;
    logic                   exp_chk;
    logic                   exp_wb;
    logic [WORD_W-1:0]      exp_rdata;
    logic [LINE_ADDR_W-1:0] exp_addr;
    logic [LINE_ADDR_W-1:0] exp_wb_addr;
    line_t                  exp_wb_line;
    logic [31:0]            rng;
    int                     errors;
    int                     tests;
    int                     failed;
    int                     l2_reqs;
    int                     reqs_at_start;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // l2 contents of a line never written back
    function automatic logic [WORD_W-1:0] model_word(input logic [LINE_ADDR_W-1:0] a,
                                                     input logic [OFFSET_W-1:0] w);
        return lcg_step(lcg_step(SEED ^ {2'b00, a, w}));
    endfunction

    function automatic line_t model_line(input logic [LINE_ADDR_W-1:0] a);
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w] = model_word(a, OFFSET_W'(w));
        end
        return l;
    endfunction

    function automatic logic [WORD_W-1:0] next_word();
        rng = lcg_step(rng);
        return rng;
    endfunction

    assign fill_line = model_line(fill_addr);

    always #2 clk = ~clk;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            l2_reqs <= 0;
        end else if (l2_req) begin
            l2_reqs <= l2_reqs + 1;
        end
    end

    dcache_top uut (
        .clk, .arst_n,
        .cpu_req, .cpu_we, .cpu_addr, .cpu_wdata,
        .cpu_busy, .cpu_done, .cpu_rdata,
        .l2_free, .l2_req, .l2_wb, .l2_addr, .l2_wb_addr, .l2_wb_line,
        .l2_rdy, .l2_rdata
    );

    dcache_l2_model #(.DELAY(3)) l2 (
        .clk, .arst_n, .stall,
        .l2_req, .l2_wb, .l2_addr, .l2_wb_addr, .l2_wb_line,
        .l2_free, .l2_rdy, .l2_rdata,
        .fill_addr, .fill_line
    );

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        errors++;
    endtask

    ////////////////////
    // checks
    ////////////////////

    a_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        !seen_req |-> (!cpu_busy && !cpu_done && !l2_req))
        else report_mismatch("cache active before the first request");
    a_hit_latency: assert property (@(posedge clk) disable iff (!arst_n)
        (exp_hit && $past(cpu_req, 2)) |-> cpu_done)
        else report_mismatch("cpu_done not 2 cycles after a hit request");
    a_hit_no_l2: assert property (@(posedge clk) disable iff (!arst_n)
        exp_hit |-> !l2_req)
        else report_mismatch("l2_req on a hit");
    a_rdata: assert property (@(posedge clk) disable iff (!arst_n)
        (cpu_done && exp_chk) |-> (cpu_rdata == exp_rdata))
        else report_mismatch($sformatf("cpu_rdata %h, expected %h",
                                       $sampled(cpu_rdata), exp_rdata));
    a_busy: assert property (@(posedge clk) disable iff (!arst_n)
        (in_flight && !cpu_req) |-> cpu_busy)
        else report_mismatch("cpu_busy low while an access is open");
    a_req_free: assert property (@(posedge clk) disable iff (!arst_n)
        l2_req |-> l2_free)
        else report_mismatch("l2_req while l2_free is low");
    a_l2_addr: assert property (@(posedge clk) disable iff (!arst_n)
        l2_req |-> (l2_addr == exp_addr && l2_wb == exp_wb))
        else report_mismatch($sformatf("l2_addr %h wb %b, expected %h wb %b",
                                       $sampled(l2_addr), $sampled(l2_wb), exp_addr, exp_wb));
    a_wb_line: assert property (@(posedge clk) disable iff (!arst_n)
        (l2_req && exp_wb) |-> (l2_wb_addr == exp_wb_addr && l2_wb_line == exp_wb_line))
        else report_mismatch($sformatf("write-back of line %h differs from the written line",
                                       $sampled(l2_wb_addr)));

    ////////////////////
    // cpu side
    ////////////////////

    task automatic start_access(input logic we, input logic [ADDR_W-1:0] addr,
                                input logic [WORD_W-1:0] wdata, input logic hit,
                                input logic [WORD_W-1:0] rd_word);
        int n;
        n = 0;
        while (cpu_busy && n < LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (cpu_busy) begin
            $display("timeout: cpu_busy stayed high for %0d cycles", LIMIT);
            errors++;
        end
        exp_hit       = hit;
        exp_chk       = !we;  // writes return no data
        exp_rdata     = rd_word;
        exp_addr      = addr[ADDR_W-1:OFFSET_W];
        reqs_at_start = l2_reqs;
        cpu_we        = we;
        cpu_addr      = addr;
        cpu_wdata     = wdata;
        cpu_req       = 1'b1;
        seen_req      = 1'b1;
        in_flight     = 1'b1;
        @(posedge clk);
        #1;
        cpu_req = 1'b0;
    endtask

    task automatic finish_access();
        int n;
        int reqs_exp;
        reqs_exp = exp_hit ? 0 : 1;
        n = 0;
        while (!cpu_done && n < LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!cpu_done) begin
            $display("timeout: no cpu_done within %0d cycles", LIMIT);
            errors++;
        end
        @(posedge clk);
        #1;
        assert (l2_reqs - reqs_at_start == reqs_exp)
            else report_mismatch($sformatf("%0d l2 requests, expected %0d",
                                           l2_reqs - reqs_at_start, reqs_exp));
        in_flight = 1'b0;
        exp_hit   = 1'b0;
        exp_chk   = 1'b0;
        exp_wb    = 1'b0;
    endtask

    task automatic access(input logic we, input logic [ADDR_W-1:0] addr,
                          input logic [WORD_W-1:0] wdata, input logic hit,
                          input logic [WORD_W-1:0] rd_word);
        start_access(we, addr, wdata, hit, rd_word);
        finish_access();
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %-14s passed", name);
        end else begin
            failed++;
            $display("test %-14s failed with %0d errors", name, errors - errs_before);
        end
    endtask

    ////////////////////
    // sequence
    ////////////////////

    initial begin : run
        int                     e0;
        logic [WORD_W-1:0]      d0;
        logic [WORD_W-1:0]      d1;
        logic [WORD_W-1:0]      d2;
        logic [LINE_ADDR_W-1:0] la;
        clk         = 1'b0;
        arst_n      = 1'b0;
        cpu_req     = 1'b0;
        cpu_we      = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        stall       = 1'b0;
        seen_req    = 1'b0;
        in_flight   = 1'b0;
        exp_hit     = 1'b0;
        exp_chk     = 1'b0;
        exp_wb      = 1'b0;
        exp_rdata   = '0;
        exp_addr    = '0;
        exp_wb_addr = '0;
        exp_wb_line = '0;
        rng         = SEED;
        errors      = 0;
        tests       = 0;
        failed      = 0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        e0 = errors;
        repeat (HOLD) @(posedge clk);  // idle cycles with no request
        #1;
        end_test("reset", e0);

        e0 = errors;
        la = {TAG_A, IDX_A};
        access(1'b0, {la, 2'd1}, '0, 1'b0, model_word(la, 2'd1));
        access(1'b0, {la, 2'd1}, '0, 1'b1, model_word(la, 2'd1));
        end_test("read_miss_hit", e0);

        e0 = errors;
        d0 = next_word();
        access(1'b1, {la, 2'd2}, d0, 1'b1, '0);
        access(1'b0, {la, 2'd2}, '0, 1'b1, d0);
        access(1'b0, {la, 2'd0}, '0, 1'b1, model_word(la, 2'd0));
        access(1'b0, {la, 2'd1}, '0, 1'b1, model_word(la, 2'd1));
        access(1'b0, {la, 2'd3}, '0, 1'b1, model_word(la, 2'd3));
        end_test("write_hit", e0);

        // T1 in way 0, T2 in way 1, then T1 touched so T2 is the lru way
        e0 = errors;
        d1 = next_word();
        d2 = next_word();
        access(1'b1, {T1, IDX_E, 2'd1}, d1, 1'b0, '0);
        access(1'b1, {T2, IDX_E, 2'd2}, d2, 1'b0, '0);
        access(1'b0, {T1, IDX_E, 2'd1}, '0, 1'b1, d1);
        exp_wb         = 1'b1;
        exp_wb_addr    = {T2, IDX_E};
        exp_wb_line    = model_line({T2, IDX_E});
        exp_wb_line[2] = d2;
        access(1'b0, {T3, IDX_E, 2'd0}, '0, 1'b0, model_word({T3, IDX_E}, 2'd0));
        exp_wb         = 1'b1;
        exp_wb_addr    = {T1, IDX_E};
        exp_wb_line    = model_line({T1, IDX_E});
        exp_wb_line[1] = d1;
        access(1'b0, {T2, IDX_E, 2'd2}, '0, 1'b0, d2);
        end_test("evict_lru", e0);

        e0 = errors;
        la = {TAG_S, IDX_S};
        stall = 1'b1;
        start_access(1'b0, {la, 2'd3}, '0, 1'b0, model_word(la, 2'd3));
        repeat (HOLD) @(posedge clk);
        #1;
        assert (l2_reqs == reqs_at_start && cpu_busy) else begin
            $display("l2 request sent or cpu_busy dropped while L2 was not free");
            errors++;
        end
        stall = 1'b0;
        finish_access();
        access(1'b0, {la, 2'd3}, '0, 1'b1, model_word(la, 2'd3));
        end_test("l2_not_free", e0);

        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
rtl/dcache_pkg.sv
rtl/dcache_array_if.sv
rtl/dcache_way_ram.sv
rtl/dcache_lookup.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verif/dcache_l2_model.sv
verif/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  # design, in compile order
  - rtl/dcache_pkg.sv
  - rtl/dcache_array_if.sv
  - rtl/dcache_way_ram.sv
  - rtl/dcache_lookup.sv
  - rtl/dcache_ctrl.sv
  - rtl/dcache_top.sv

  # testbench
  - target: test
    files:
      - verif/dcache_l2_model.sv
      - verif/dcache_tb.sv
